/* hdl/fmul_pkg.sv */
`default_nettype none

package fmul_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // single-precision format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int exp_w    = 8;
  localparam int mant_w   = 23;
  localparam int exp_bias = 127;
  localparam int exp_max  = 255;   // all-ones exponent field.

  localparam int sig_w  = mant_w + 1;   // fraction with the hidden one.
  localparam int prod_w = 2 * sig_w;

  typedef logic [31:0] word_t;

  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [mant_w-1:0] frac;
  } operand_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // exception flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int flag_nv = 4;   // invalid operation.
  localparam int flag_dz = 3;
  localparam int flag_of = 2;
  localparam int flag_uf = 1;
  localparam int flag_nx = 0;

  typedef logic [4:0] flags_t;

  // special-case code, decided once in the first stage.
  typedef enum logic [2:0] {
    spec_none,
    spec_nan,
    spec_inv,    // infinity times zero.
    spec_inf,
    spec_zero
  } special_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    operand_t a;
    operand_t b;
    special_e spec;
  } stage1_t;

  // the exponent is signed so the bias subtraction cannot wrap.
  typedef struct packed {
    logic               sign;
    logic signed [9:0]  exp;
    logic [prod_w-1:0]  prod;
    special_e           spec;
  } product_t;

endpackage

`default_nettype wire

/* hdl/fmul_classify.sv */
`timescale 1ns/1ps
`default_nettype none

module fmul_classify import fmul_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  input  wire     word_t op_a,
  input  wire     word_t op_b,
  input  wire     valid_in,
  input  wire     ready_in,
  output logic    ready_out,
  output logic    valid_out,
  output stage1_t stage_out
);

  operand_t a;
  operand_t b;
  logic     nan_a;
  logic     nan_b;
  logic     inf_a;
  logic     inf_b;
  logic     zero_a;
  logic     zero_b;
  special_e spec;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // unpack and classify
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign a = operand_t'(op_a);
  assign b = operand_t'(op_b);

  assign nan_a = (a.exp == exp_w'(exp_max)) && (a.frac != '0);
  assign nan_b = (b.exp == exp_w'(exp_max)) && (b.frac != '0);
  assign inf_a = (a.exp == exp_w'(exp_max)) && (a.frac == '0);
  assign inf_b = (b.exp == exp_w'(exp_max)) && (b.frac == '0);

  // subnormals are flushed, so any zero exponent field reads as zero.
  assign zero_a = (a.exp == '0);
  assign zero_b = (b.exp == '0);

  always_comb begin
    if (nan_a || nan_b) begin
      spec = spec_nan;
    end else if ((inf_a && zero_b) || (inf_b && zero_a)) begin
      spec = spec_inv;
    end else if (inf_a || inf_b) begin
      spec = spec_inf;
    end else if (zero_a || zero_b) begin
      spec = spec_zero;
    end else begin
      spec = spec_none;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign ready_out = !valid_out || ready_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_out && valid_in) begin
      stage_out <= '{a: a, b: b, spec: spec};
    end
  end

endmodule

`default_nettype wire

/* hdl/fmul_mant_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module fmul_mant_mult import fmul_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      valid_in,
  input  wire      stage1_t stage_in,
  input  wire      ready_in,
  output logic     ready_out,
  output logic     valid_out,
  output product_t stage_out
);

  logic [sig_w-1:0]  sig_a;
  logic [sig_w-1:0]  sig_b;
  logic signed [9:0] exp_a;
  logic signed [9:0] exp_b;
  product_t          prod_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sign, exponent and mantissa product
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // zero operands are already coded as special, so the hidden one is always set.
  assign sig_a = {1'b1, stage_in.a.frac};
  assign sig_b = {1'b1, stage_in.b.frac};

  assign exp_a = $signed({2'b00, stage_in.a.exp});
  assign exp_b = $signed({2'b00, stage_in.b.exp});

  always_comb begin
    prod_d.sign = stage_in.a.sign ^ stage_in.b.sign;
    prod_d.exp  = exp_a + exp_b - $signed(10'(exp_bias));
    prod_d.prod = prod_w'(sig_a) * prod_w'(sig_b);   // 24 x 24 gives the full 48 bits.
    prod_d.spec = stage_in.spec;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign ready_out = !valid_out || ready_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_out && valid_in) begin
      stage_out <= prod_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/fmul_round_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module fmul_round_pack import fmul_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  input  wire    valid_in,
  input  wire    product_t stage_in,
  input  wire    ready_in,
  output logic   ready_out,
  output logic   valid_out,
  output word_t  result,
  output flags_t flags
);

  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [mant_w-1:0] frac;
    special_e          spec;
  } rounded_t;

  // handshake of the normalize, round and pack stages.
  logic norm_valid;
  logic norm_ready;
  logic rnd_valid;
  logic rnd_ready;
  logic out_ready;

  product_t norm_d;
  product_t norm_q;
  logic     sticky_d;
  logic     sticky_q;

  logic [sig_w-1:0]  kept;
  logic              guard;
  logic              rnd;
  logic              sticky;
  logic              round_up;
  logic [sig_w:0]    rounded;
  logic signed [9:0] exp_inc;
  rounded_t          rnd_d;
  rounded_t          rnd_q;

  word_t  result_d;
  flags_t flags_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 3 normalizes the product
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    norm_d   = stage_in;
    sticky_d = 1'b0;
    if (stage_in.prod[prod_w-1]) begin   // product in [2, 4).
      norm_d.prod = stage_in.prod >> 1;
      norm_d.exp  = stage_in.exp + 10'sd1;
      sticky_d    = stage_in.prod[0];
    end
  end

  assign norm_ready = !norm_valid || rnd_ready;
  assign ready_out  = norm_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      norm_valid <= 1'b0;
    end else if (norm_ready) begin
      norm_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (norm_ready && valid_in) begin
      norm_q   <= norm_d;
      sticky_q <= sticky_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 4 rounds to nearest even
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign kept   = norm_q.prod[prod_w-2 -: sig_w];   // leading one sits at bit 46.
  assign guard  = norm_q.prod[mant_w-1];
  assign rnd    = norm_q.prod[mant_w-2];
  assign sticky = (|norm_q.prod[mant_w-3:0]) || sticky_q;

  assign round_up = guard && (rnd || sticky || kept[0]);
  assign rounded  = {1'b0, kept} + (sig_w + 1)'(round_up);
  assign exp_inc  = norm_q.exp + 10'sd1;

  always_comb begin
    rnd_d.sign = norm_q.sign;
    rnd_d.spec = norm_q.spec;
    if (rounded[sig_w]) begin   // the carry out wrapped the mantissa to 2.0.
      rnd_d.exp  = exp_inc[exp_w-1:0];
      rnd_d.frac = rounded[sig_w-1:1];
    end else begin
      rnd_d.exp  = norm_q.exp[exp_w-1:0];
      rnd_d.frac = rounded[mant_w-1:0];
    end
  end

  assign out_ready = !valid_out || ready_in;
  assign rnd_ready = !rnd_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rnd_valid <= 1'b0;
    end else if (rnd_ready) begin
      rnd_valid <= norm_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rnd_ready && norm_valid) begin
      rnd_q <= rnd_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 5 packs the result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    flags_d = '0;
    case (rnd_q.spec)
      spec_nan:  result_d = 32'h7fc0_0000;   // default quiet NaN.
      spec_inv:  result_d = 32'hffc0_0000;
      spec_inf:  result_d = {rnd_q.sign, 8'hff, 23'h0};
      spec_zero: result_d = {rnd_q.sign, 31'h0};
      default:   result_d = {rnd_q.sign, rnd_q.exp, rnd_q.frac};
    endcase
    flags_d[flag_nv] = (rnd_q.spec == spec_nan) || (rnd_q.spec == spec_inv);
    // range and precision exceptions are not detected.
    flags_d[flag_dz] = 1'b0;
    flags_d[flag_of] = 1'b0;
    flags_d[flag_uf] = 1'b0;
    flags_d[flag_nx] = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else if (out_ready) begin
      valid_out <= rnd_valid;
      if (rnd_valid) begin
        result <= result_d;
        flags  <= flags_d;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/fp_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_multiplier import fmul_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  input  wire    word_t op_a,
  input  wire    word_t op_b,
  input  wire    start,
  input  wire    ready_in,
  output logic   ready_out,
  output logic   valid_out,
  output word_t  result,
  output flags_t flags
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage boundaries
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic     s1_valid;
  logic     s1_ready;
  stage1_t  s1_data;

  logic     s2_valid;
  logic     s2_ready;
  product_t s2_data;

  // stage 1, operand classification.
  fmul_classify u_classify (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .valid_in  (start),
    .ready_in  (s1_ready),
    .ready_out (ready_out),
    .valid_out (s1_valid),
    .stage_out (s1_data)
  );

  // stage 2, mantissa product.
  fmul_mant_mult u_mant_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (s1_valid),
    .stage_in  (s1_data),
    .ready_in  (s2_ready),
    .ready_out (s1_ready),
    .valid_out (s2_valid),
    .stage_out (s2_data)
  );

  // stages 3 to 5, normalize, round and pack.
  fmul_round_pack u_round_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (s2_valid),
    .stage_in  (s2_data),
    .ready_in  (ready_in),
    .ready_out (s2_ready),
    .valid_out (valid_out),
    .result    (result),
    .flags     (flags)
  );

endmodule

`default_nettype wire

/* sim/tb_fp_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_multiplier import fmul_pkg::*;;

  localparam int num_ops    = 2000;
  localparam int num_stream = 20;
  // random ops see ready_in at 60 percent and take about 1.7 cycles each.
  localparam int max_cycles = 8000;

  logic   clk = 1'b0;
  logic   rst_n;
  word_t  op_a;
  word_t  op_b;
  logic   start;
  logic   ready_in;
  logic   ready_out;
  logic   valid_out;
  word_t  result;
  flags_t flags;

  integer      seed;
  int          cycle = 0;
  int          accepted = 0;
  int          checked = 0;
  logic        accepted_now = 1'b0;
  logic        stream_mode = 1'b0;
  int          stream_accepts = 0;
  int          stream_takes = 0;
  int          first_accept_cycle;
  int          last_take_cycle;
  logic [36:0] exp_q[$];   // {flags, result} per accepted operation.

  fp_multiplier dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .start     (start),
    .ready_in  (ready_in),
    .ready_out (ready_out),
    .valid_out (valid_out),
    .result    (result),
    .flags     (flags)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= max_cycles) begin
      stop_with_failure("timeout: the run did not finish within the cycle limit");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reporting and checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                  name, got, expected));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [36:0] expected_product(input word_t a, input word_t b);
    logic        s;
    logic [7:0]  ea;
    logic [7:0]  eb;
    logic [22:0] fa;
    logic [22:0] fb;
    logic        nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
    logic [47:0] p;
    logic        shifted_out;
    logic        g, r, st, up;
    logic [24:0] m;
    int          e;
    word_t       res;
    flags_t      fl;
    s  = a[31] ^ b[31];
    ea = a[30:23];
    eb = b[30:23];
    fa = a[22:0];
    fb = b[22:0];
    fl = '0;
    nan_a  = (ea == 8'hff) && (fa != 23'h0);
    nan_b  = (eb == 8'hff) && (fb != 23'h0);
    inf_a  = (ea == 8'hff) && (fa == 23'h0);
    inf_b  = (eb == 8'hff) && (fb == 23'h0);
    zero_a = (ea == 8'h00);   // subnormals count as zero.
    zero_b = (eb == 8'h00);
    if (nan_a || nan_b) begin
      res = 32'h7fc0_0000;
      fl[flag_nv] = 1'b1;
    end else if ((inf_a && zero_b) || (inf_b && zero_a)) begin
      res = 32'hffc0_0000;
      fl[flag_nv] = 1'b1;
    end else if (inf_a || inf_b) begin
      res = {s, 8'hff, 23'h0};
    end else if (zero_a || zero_b) begin
      res = {s, 31'h0};
    end else begin
      p = {24'h0, 1'b1, fa} * {24'h0, 1'b1, fb};
      e = int'(ea) + int'(eb) - 127;
      shifted_out = 1'b0;
      if (p[47]) begin
        shifted_out = p[0];
        p = p >> 1;
        e = e + 1;
      end
      g  = p[22];
      r  = p[21];
      st = (|p[20:0]) || shifted_out;
      up = g && (r || st || p[23]);
      m  = {1'b0, p[46:23]} + 25'(up);
      if (m[24]) begin   // rounding carried into a new leading bit.
        m = m >> 1;
        e = e + 1;
      end
      res = {s, e[7:0], m[22:0]};
    end
    return {fl, res};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic word_t random_operand();
    logic [31:0] r;
    logic [7:0]  e;
    logic [22:0] f;
    int          kind;
    r    = $random(seed);
    f    = r[22:0];
    kind = $unsigned($random(seed)) % 24;
    case (kind)
      0:       e = 8'h00;   // a zero exponent flushes the fraction.
      1: begin
        e = 8'hff;
        f = 23'h0;
      end
      2: begin
        e = 8'hff;
        f = f | 23'h1;
      end
      default: e = 8'(64 + $unsigned($random(seed)) % 127);
    endcase
    // short fractions give exact halfway products often.
    if (kind >= 3 && kind < 9) f[10:0] = 11'h0;
    return {r[31], e, f};
  endfunction

  task automatic take_result();
    logic [36:0] expv;
    if (exp_q.size() == 0) begin
      stop_with_failure("a result appeared with no operation outstanding");
    end else begin
      expv = exp_q.pop_front();
      check_value("result", result, expv[31:0]);
      check_value("flags", 32'(flags), 32'(expv[36:32]));
      checked++;
      if (stream_mode) begin
        if (stream_takes == 0) begin
          check_value("latency", cycle - first_accept_cycle, 5);
        end else begin
          check_value("result spacing", cycle - last_take_cycle, 1);
        end
        last_take_cycle = cycle;
        stream_takes++;
      end
    end
  endtask

  task automatic accept_operation();
    exp_q.push_back(expected_product(op_a, op_b));
    accepted++;
    accepted_now = 1'b1;
    if (stream_mode) begin
      if (stream_accepts == 0) first_accept_cycle = cycle;
      stream_accepts++;
    end
  endtask

  // handshakes are sampled at the falling edge and inputs change after the rising one.
  task automatic step();
    @(negedge clk);
    accepted_now = 1'b0;
    if (valid_out && ready_in) take_result();
    if (start && ready_out) accept_operation();
    @(posedge clk);
    #0.5;
  endtask

  task automatic issue_op(input word_t a, input word_t b);
    op_a  = a;
    op_b  = b;
    start = 1'b1;
    step();
    while (!accepted_now) step();
    start = 1'b0;
  endtask

  task automatic drain();
    start    = 1'b0;
    ready_in = 1'b1;
    while (exp_q.size() != 0) step();
  endtask

  initial begin
    seed     = 79364;
    rst_n    = 1'b0;
    start    = 1'b0;
    op_a     = '0;
    op_b     = '0;
    ready_in = 1'b0;
    repeat (8) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    @(negedge clk);
    check_value("valid_out", 32'(valid_out), 0);
    check_value("ready_out", 32'(ready_out), 1);
    check_value("result", result, 0);
    check_value("flags", 32'(flags), 0);
    @(posedge clk);
    #0.5;

    // ties, a rounding carry and the special cases with their signs.
    ready_in = 1'b1;
    issue_op(32'h3f80_0001, 32'h3fc0_0000);
    issue_op(32'h3f80_0003, 32'h3fc0_0000);
    issue_op(32'h3fb5_04f3, 32'h3fb5_04f3);
    issue_op(32'h7f80_0000, 32'h8000_0000);
    issue_op(32'hff80_0000, 32'h4000_0000);
    issue_op(32'h8000_0000, 32'h4040_0000);
    issue_op(32'h7fc0_0001, 32'h3f80_0000);
    issue_op(32'h0001_2345, 32'hc000_0000);

    // a refused start keeps its operands during random traffic with back-pressure.
    while (accepted < num_ops - num_stream) begin
      if (!start || accepted_now) begin
        start = ($unsigned($random(seed)) % 10) < 7;
        op_a  = random_operand();
        op_b  = random_operand();
      end
      ready_in = ($unsigned($random(seed)) % 10) < 6;
      step();
    end
    drain();

    stream_mode = 1'b1;
    repeat (num_stream) begin
      op_a  = random_operand();
      op_b  = random_operand();
      start = 1'b1;
      step();
    end
    drain();
    stream_mode = 1'b0;
    check_value("stream accepts", stream_accepts, num_stream);

    // any result after the drain has no operation behind it.
    repeat (6) step();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* fp_multiplier.f */
hdl/fmul_pkg.sv
hdl/fmul_classify.sv
hdl/fmul_mant_mult.sv
hdl/fmul_round_pack.sv
hdl/fp_multiplier.sv
sim/tb_fp_multiplier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the fp_multiplier testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  --top-module tb_fp_multiplier \
  -f fp_multiplier.f \
  -o sim_fp_multiplier

# the simulator stops with a non-zero status on failure, the log decides.
./obj_dir/sim_fp_multiplier > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
